//--- list.f
+incdir+hdl
hdl/br_isa_pkg.sv
hdl/br_pred_pkg.sv
hdl/branch_cond.sv
hdl/fu_br.sv
hdl/ex_issue_regs.sv
hdl/br_perf_regs.sv
hdl/br_ex_top.sv
verif/br_ex_checker.sv
verif/tb_br_ex.sv

//--- Bender.yml
package:
  name: br_ex

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/br_isa_pkg.sv
      - hdl/br_pred_pkg.sv
      - hdl/branch_cond.sv
      - hdl/fu_br.sv
      - hdl/ex_issue_regs.sv
      - hdl/br_perf_regs.sv
      - hdl/br_ex_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/br_ex_checker.sv
      - verif/tb_br_ex.sv

//--- verif/tb_br_ex.sv
`include "br_consts.svh"
`timescale 1ns/1ps

module tb_br_ex;

    import br_isa_pkg::*;
    import br_pred_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int RAND_CYCLES  = 600;
    localparam int TAIL_CYCLES  = 12;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + RAND_CYCLES + TAIL_CYCLES + 2) * 20 + 400;

    integer     seed;
    logic       clk = 1'b0;
    logic       arst_n;
    logic       issue_valid_a, issue_valid_b, br_pd_a, br_pd_b, stall, perf_clr;
    addr_t      pc_a, pc_b, pc_pd_a, pc_pd_b;
    word_t      rdata_a1, rdata_a2, rdata_b1, rdata_b2, imm_a, imm_b;
    br_type_e   br_type_a, br_type_b;
    pd_type_t   pd_type_a, pd_type_b, pred_upd_type;
    perf_addr_t perf_addr;
    perf_cnt_t  perf_rdata;
    logic       redirect, redirect_a, pred_upd_valid, pred_upd_jump;
    addr_t      redirect_pc, pred_upd_pc, pred_upd_target;
    int         err_cnt, chk_cnt;                  // from the checker

    // model of the ex register
    logic       m_valid_a, m_valid_b, m_pd_a, m_pd_b;
    addr_t      m_pc_a, m_pc_b, m_pc_pd_a, m_pc_pd_b;
    word_t      m_r1_a, m_r2_a, m_r1_b, m_r2_b, m_imm_a, m_imm_b;
    br_type_e   m_type_a, m_type_b;
    pd_type_t   m_pdt_a, m_pdt_b;

    // reference results
    logic       tk_a, tk_b, ms_a, ms_b, sel_b;
    addr_t      tg_a, tg_b;
    logic       exp_redirect, exp_redirect_a, exp_upd_valid, exp_upd_jump;
    addr_t      exp_redirect_pc, exp_upd_pc, exp_upd_target;
    pd_type_t   exp_upd_type;

    always #10 clk = ~clk;                         // 20 ns period

    br_ex_top i_dut (.*);

    br_ex_checker i_chk (
        .*,
        .ex_valid_a(m_valid_a), .ex_valid_b(m_valid_b),
        .ex_type_a(m_type_a), .ex_type_b(m_type_b)
    );

    // real direction from the compare rules
    function automatic logic ref_taken(br_type_e t, word_t r1, word_t r2);
        case (t)
            BR_BEQ:  return r1 == r2;
            BR_BNE:  return r1 != r2;
            BR_BLT:  return $signed(r1) < $signed(r2);
            BR_BGE:  return $signed(r1) >= $signed(r2);
            BR_BLTU: return r1 < r2;
            BR_BGEU: return r1 >= r2;
            BR_B, BR_BL, BR_JIRL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic addr_t ref_target(br_type_e t, addr_t pc, word_t imm, word_t r1);
        return (t == BR_JIRL) ? r1 + imm : pc + imm;
    endfunction

    // restart pc of a mispredicted slot
    function automatic addr_t ref_fix_pc(logic tk, addr_t tg, addr_t pc);
        return tk ? tg : pc + `INST_BYTES;
    endfunction

    assign tk_a  = ref_taken(m_type_a, m_r1_a, m_r2_a);
    assign tk_b  = ref_taken(m_type_b, m_r1_b, m_r2_b);
    assign tg_a  = ref_target(m_type_a, m_pc_a, m_imm_a, m_r1_a);
    assign tg_b  = ref_target(m_type_b, m_pc_b, m_imm_b, m_r1_b);
    assign ms_a  = m_valid_a && (m_type_a != BR_NONE) && (m_pd_a != tk_a || m_pc_pd_a != tg_a);
    assign ms_b  = m_valid_b && (m_type_b != BR_NONE) && (m_pd_b != tk_b || m_pc_pd_b != tg_b);
    assign sel_b = (m_pdt_a == 2'd0);              // a not control flow

    assign exp_redirect_a  = ms_a;
    assign exp_redirect    = ms_a | ms_b;
    assign exp_redirect_pc = ms_a ? ref_fix_pc(tk_a, tg_a, m_pc_a) : ref_fix_pc(tk_b, tg_b, m_pc_b);
    assign exp_upd_valid   = sel_b ? (m_valid_b && m_pdt_b != 2'd0)
                                   : (m_valid_a && m_pdt_a != 2'd0);
    assign exp_upd_pc      = sel_b ? m_pc_b : m_pc_a;
    assign exp_upd_type    = sel_b ? m_pdt_b : m_pdt_a;
    assign exp_upd_target  = sel_b ? tg_b : tg_a;
    assign exp_upd_jump    = sel_b ? tk_b : tk_a;

    // capture, hold on stall, load empty behind a redirect
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid_a <= 1'b0;
            m_valid_b <= 1'b0;
        end else if (!stall) begin
            m_valid_a <= issue_valid_a && !exp_redirect;
            m_valid_b <= issue_valid_b && !exp_redirect;
        end
    end

    always @(posedge clk) begin
        if (!stall) begin
            m_pc_a    <= pc_a;
            m_pc_b    <= pc_b;
            m_r1_a    <= rdata_a1;
            m_r2_a    <= rdata_a2;
            m_r1_b    <= rdata_b1;
            m_r2_b    <= rdata_b2;
            m_imm_a   <= imm_a;
            m_imm_b   <= imm_b;
            m_type_a  <= br_type_a;
            m_type_b  <= br_type_b;
            m_pd_a    <= br_pd_a;
            m_pd_b    <= br_pd_b;
            m_pc_pd_a <= pc_pd_a;
            m_pc_pd_b <= pc_pd_b;
            m_pdt_a   <= pd_type_a;
            m_pdt_b   <= pd_type_b;
        end
    end

    // boundary values show up often
    function automatic word_t pick_operand();
        case ($unsigned($random(seed)) % 8)
            0:       return 32'h0000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'hffff_ffff;
            4:       return 32'h0000_0001;
            default: return $random(seed);
        endcase
    endfunction

    task automatic gen_slot(output logic v, output addr_t pc, output word_t r1,
                            output word_t r2, output word_t imm, output br_type_e t,
                            output logic pd, output addr_t pc_pd, output pd_type_t pdt);
        int    mode;
        logic  tk;
        addr_t tgt;
        v     = ($unsigned($random(seed)) % 8) != 0;
        t     = br_type_e'(4'($unsigned($random(seed)) % 10));
        pc    = $random(seed);
        pc[1:0] = 2'b00;                           // word aligned
        imm   = ($random(seed) % 2048) * 4;        // signed offset
        r1    = pick_operand();
        r2    = pick_operand();
        pdt   = pd_type_t'($unsigned($random(seed)) % 4);
        tk    = ref_taken(t, r1, r2);
        tgt   = ref_target(t, pc, imm, r1);
        mode  = $unsigned($random(seed)) % 6;      // 0..2 correct prediction
        pd    = tk;
        pc_pd = tgt;
        if (mode == 3) begin
            pd = ~tk;                              // wrong direction only
        end else if (mode == 4) begin
            pc_pd = tgt + addr_t'((1 + $unsigned($random(seed)) % 8) * `INST_BYTES);
        end else if (mode == 5) begin
            pd    = $random(seed);
            pc_pd = $random(seed);
        end
    endtask

    initial begin
        seed = 92;
        arst_n = 1'b0;
        {issue_valid_a, issue_valid_b, br_pd_a, br_pd_b, stall, perf_clr} = '0;
        {pc_a, pc_b, pc_pd_a, pc_pd_b} = '0;
        {rdata_a1, rdata_a2, rdata_b1, rdata_b2, imm_a, imm_b} = '0;
        br_type_a = BR_NONE;
        br_type_b = BR_NONE;
        {pd_type_a, pd_type_b, perf_addr} = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        repeat (RAND_CYCLES) begin
            gen_slot(issue_valid_a, pc_a, rdata_a1, rdata_a2, imm_a, br_type_a,
                     br_pd_a, pc_pd_a, pd_type_a);
            gen_slot(issue_valid_b, pc_b, rdata_b1, rdata_b2, imm_b, br_type_b,
                     br_pd_b, pc_pd_b, pd_type_b);
            stall     = ($unsigned($random(seed)) % 8) == 0;
            perf_clr  = ($unsigned($random(seed)) % 50) == 0;
            perf_addr = perf_addr_t'($unsigned($random(seed)) % 4);
            @(negedge clk);
        end
        // idle sweep of the perf registers around a clear
        issue_valid_a = 1'b0;
        issue_valid_b = 1'b0;
        stall         = 1'b0;
        for (int i = 0; i < TAIL_CYCLES; i++) begin
            perf_addr = perf_addr_t'(i % 4);
            perf_clr  = (i == 4);
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the stimulus did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

endmodule

//--- verif/br_ex_checker.sv
`include "br_consts.svh"
`timescale 1ns/1ps

module br_ex_checker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    stall,
    input  logic                    perf_clr,
    input  br_pred_pkg::perf_addr_t perf_addr,
    input  logic                    ex_valid_a,       // model ex contents
    input  logic                    ex_valid_b,
    input  br_isa_pkg::br_type_e    ex_type_a,
    input  br_isa_pkg::br_type_e    ex_type_b,
    input  logic                    exp_redirect,     // reference results
    input  logic                    exp_redirect_a,
    input  br_isa_pkg::addr_t       exp_redirect_pc,
    input  logic                    exp_upd_valid,
    input  br_isa_pkg::addr_t       exp_upd_pc,
    input  br_pred_pkg::pd_type_t   exp_upd_type,
    input  br_isa_pkg::addr_t       exp_upd_target,
    input  logic                    exp_upd_jump,
    input  logic                    redirect,         // dut ports
    input  logic                    redirect_a,
    input  br_isa_pkg::addr_t       redirect_pc,
    input  logic                    pred_upd_valid,
    input  br_isa_pkg::addr_t       pred_upd_pc,
    input  br_pred_pkg::pd_type_t   pred_upd_type,
    input  br_isa_pkg::addr_t       pred_upd_target,
    input  logic                    pred_upd_jump,
    input  br_pred_pkg::perf_cnt_t  perf_rdata,
    output int                      err_cnt,
    output int                      chk_cnt
);

    import br_isa_pkg::*;
    import br_pred_pkg::*;

    perf_cnt_t cnt_br, cnt_miss, cnt_last, exp_rdata;  // expected perf regs
    logic      held, held_redirect, flushed;           // state of the last edge
    addr_t     held_pc;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    initial begin
        err_cnt = 0;
        chk_cnt = 0;
    end

    // sample before this edge lands in any register
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_br   = '0;
            cnt_miss = '0;
            cnt_last = '0;
            held     = 1'b0;
            flushed  = 1'b0;
        end else begin
            case (perf_addr)
                `PERF_ADDR_BR:   exp_rdata = cnt_br;
                `PERF_ADDR_MISS: exp_rdata = cnt_miss;
                `PERF_ADDR_LAST: exp_rdata = cnt_last;
                default:         exp_rdata = '0;
            endcase
            check_val("perf_rdata", exp_rdata, perf_rdata);
            check_val("redirect", exp_redirect, redirect);
            check_val("redirect_a", exp_redirect_a, redirect_a);
            if (exp_redirect)
                check_val("redirect_pc", exp_redirect_pc, redirect_pc);
            check_val("pred_upd_valid", exp_upd_valid, pred_upd_valid);
            if (exp_upd_valid) begin                   // fields only matter when valid
                check_val("pred_upd_pc", exp_upd_pc, pred_upd_pc);
                check_val("pred_upd_type", exp_upd_type, pred_upd_type);
                check_val("pred_upd_target", exp_upd_target, pred_upd_target);
                check_val("pred_upd_jump", exp_upd_jump, pred_upd_jump);
            end
            if (held) begin                            // stalled last edge
                check_val("redirect under stall", held_redirect, redirect);
                if (held_redirect)
                    check_val("redirect_pc under stall", held_pc, redirect_pc);
            end
            if (flushed) begin                         // wrong-path pair dropped
                check_val("redirect after flush", 1'b0, redirect);
                check_val("pred_upd_valid after flush", 1'b0, pred_upd_valid);
            end
            held          = stall;
            held_redirect = exp_redirect;
            held_pc       = exp_redirect_pc;
            flushed       = exp_redirect && !stall;
            if (perf_clr) begin
                cnt_br   = '0;
                cnt_miss = '0;
                cnt_last = '0;
            end else if ((ex_valid_a || ex_valid_b) && !stall) begin
                if (ex_valid_a && ex_type_a != BR_NONE)
                    cnt_br = cnt_br + 1;
                if (ex_valid_b && ex_type_b != BR_NONE && !exp_redirect_a)
                    cnt_br = cnt_br + 1;               // b killed by older redirect
                if (exp_redirect) begin
                    cnt_miss = cnt_miss + 1;
                    cnt_last = exp_redirect_pc;
                end
            end
        end
    end

endmodule

//--- hdl/br_ex_top.sv
`timescale 1ns/1ps

module br_ex_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   issue_valid_a,
    input  logic                   issue_valid_b,
    input  br_isa_pkg::addr_t      pc_a,
    input  br_isa_pkg::addr_t      pc_b,
    input  br_isa_pkg::word_t      rdata_a1,
    input  br_isa_pkg::word_t      rdata_a2,
    input  br_isa_pkg::word_t      rdata_b1,
    input  br_isa_pkg::word_t      rdata_b2,
    input  br_isa_pkg::word_t      imm_a,
    input  br_isa_pkg::word_t      imm_b,
    input  br_isa_pkg::br_type_e   br_type_a,
    input  br_isa_pkg::br_type_e   br_type_b,
    input  logic                   br_pd_a,
    input  logic                   br_pd_b,
    input  br_isa_pkg::addr_t      pc_pd_a,
    input  br_isa_pkg::addr_t      pc_pd_b,
    input  br_pred_pkg::pd_type_t  pd_type_a,
    input  br_pred_pkg::pd_type_t  pd_type_b,
    input  logic                   stall,          // memory stall level
    input  logic                   perf_clr,
    input  br_pred_pkg::perf_addr_t perf_addr,
    output br_pred_pkg::perf_cnt_t perf_rdata,
    output logic                   redirect,
    output br_isa_pkg::addr_t      redirect_pc,
    output logic                   redirect_a,
    output logic                   pred_upd_valid,
    output br_isa_pkg::addr_t      pred_upd_pc,
    output br_pred_pkg::pd_type_t  pred_upd_type,
    output br_isa_pkg::addr_t      pred_upd_target,
    output logic                   pred_upd_jump
);

    import br_isa_pkg::*;
    import br_pred_pkg::*;

    logic     ex_valid_a, ex_valid_b;               // registered slot valids
    addr_t    ex_pc_a, ex_pc_b;
    word_t    ex_rdata_a1, ex_rdata_a2;
    word_t    ex_rdata_b1, ex_rdata_b2;
    word_t    ex_imm_a, ex_imm_b;
    br_type_e ex_br_type_a, ex_br_type_b;
    logic     ex_br_pd_a, ex_br_pd_b;
    addr_t    ex_pc_pd_a, ex_pc_pd_b;
    pd_type_t ex_pd_type_a, ex_pd_type_b;

    ex_issue_regs i_ex_regs (
        .clk, .arst_n, .stall,
        .flush(redirect),                           // kill same-cycle issue
        .issue_valid_a, .issue_valid_b, .pc_a, .pc_b,
        .rdata_a1, .rdata_a2, .rdata_b1, .rdata_b2, .imm_a, .imm_b,
        .br_type_a, .br_type_b, .br_pd_a, .br_pd_b,
        .pc_pd_a, .pc_pd_b, .pd_type_a, .pd_type_b,
        .ex_valid_a, .ex_valid_b, .ex_pc_a, .ex_pc_b,
        .ex_rdata_a1, .ex_rdata_a2, .ex_rdata_b1, .ex_rdata_b2,
        .ex_imm_a, .ex_imm_b, .ex_br_type_a, .ex_br_type_b,
        .ex_br_pd_a, .ex_br_pd_b, .ex_pc_pd_a, .ex_pc_pd_b,
        .ex_pd_type_a, .ex_pd_type_b
    );

    fu_br i_fu_br (
        .valid_a(ex_valid_a), .valid_b(ex_valid_b),
        .pc_a(ex_pc_a), .pc_b(ex_pc_b),
        .rdata_a1(ex_rdata_a1), .rdata_a2(ex_rdata_a2),
        .rdata_b1(ex_rdata_b1), .rdata_b2(ex_rdata_b2),
        .imm_a(ex_imm_a), .imm_b(ex_imm_b),
        .br_type_a(ex_br_type_a), .br_type_b(ex_br_type_b),
        .br_pd_a(ex_br_pd_a), .br_pd_b(ex_br_pd_b),
        .pc_pd_a(ex_pc_pd_a), .pc_pd_b(ex_pc_pd_b),
        .pd_type_a(ex_pd_type_a), .pd_type_b(ex_pd_type_b),
        .redirect_a, .redirect, .redirect_pc,
        .pred_upd_valid, .pred_upd_pc, .pred_upd_type,
        .pred_upd_target, .pred_upd_jump
    );

    br_perf_regs i_perf (
        .clk, .arst_n, .stall,
        .ex_valid_a, .ex_valid_b,
        .ex_type_a(ex_br_type_a), .ex_type_b(ex_br_type_b),
        .redirect_a, .redirect, .redirect_pc,
        .perf_clr, .perf_addr, .perf_rdata
    );

endmodule

//--- hdl/br_perf_regs.sv
`include "br_consts.svh"
`timescale 1ns/1ps

module br_perf_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   stall,
    input  logic                   ex_valid_a,
    input  logic                   ex_valid_b,
    input  br_isa_pkg::br_type_e   ex_type_a,
    input  br_isa_pkg::br_type_e   ex_type_b,
    input  logic                   redirect_a,     // slot a kills slot b
    input  logic                   redirect,
    input  br_isa_pkg::addr_t      redirect_pc,
    input  logic                   perf_clr,       // one-cycle clear pulse
    input  br_pred_pkg::perf_addr_t perf_addr,
    output br_pred_pkg::perf_cnt_t perf_rdata
);

    import br_isa_pkg::*;
    import br_pred_pkg::*;

    perf_cnt_t br_cnt;                              // resolved branches
    perf_cnt_t miss_cnt;                            // redirects taken
    addr_t     last_pc;                             // latest redirect pc
    logic      upd;                                 // pair retires this edge
    logic      hit_a, hit_b;                        // slot counts as branch
    perf_cnt_t br_inc;                              // 0, 1 or 2

    assign upd    = (ex_valid_a | ex_valid_b) & ~stall;   // once per pair
    assign hit_a  = ex_valid_a && (ex_type_a != BR_NONE);
    assign hit_b  = ex_valid_b && (ex_type_b != BR_NONE) && !redirect_a;
    assign br_inc = perf_cnt_t'(hit_a) + perf_cnt_t'(hit_b);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            br_cnt   <= '0;
            miss_cnt <= '0;
            last_pc  <= '0;
        end else if (perf_clr) begin               // clear wins over count
            br_cnt   <= '0;
            miss_cnt <= '0;
            last_pc  <= '0;
        end else if (upd) begin
            br_cnt <= br_cnt + br_inc;
            if (redirect) begin
                miss_cnt <= miss_cnt + perf_cnt_t'(1);
                last_pc  <= redirect_pc;
            end
        end
    end

    always_comb begin
        case (perf_addr)
            `PERF_ADDR_BR:   perf_rdata = br_cnt;
            `PERF_ADDR_MISS: perf_rdata = miss_cnt;
            `PERF_ADDR_LAST: perf_rdata = perf_cnt_t'(last_pc);
            default:         perf_rdata = '0;       // unmapped slot
        endcase
    end

endmodule

//--- hdl/ex_issue_regs.sv
`timescale 1ns/1ps

module ex_issue_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  stall,           // hold the ex stage
    input  logic                  flush,           // drop the incoming pair
    input  logic                  issue_valid_a,
    input  logic                  issue_valid_b,
    input  br_isa_pkg::addr_t     pc_a,
    input  br_isa_pkg::addr_t     pc_b,
    input  br_isa_pkg::word_t     rdata_a1,
    input  br_isa_pkg::word_t     rdata_a2,
    input  br_isa_pkg::word_t     rdata_b1,
    input  br_isa_pkg::word_t     rdata_b2,
    input  br_isa_pkg::word_t     imm_a,
    input  br_isa_pkg::word_t     imm_b,
    input  br_isa_pkg::br_type_e  br_type_a,
    input  br_isa_pkg::br_type_e  br_type_b,
    input  logic                  br_pd_a,
    input  logic                  br_pd_b,
    input  br_isa_pkg::addr_t     pc_pd_a,
    input  br_isa_pkg::addr_t     pc_pd_b,
    input  br_pred_pkg::pd_type_t pd_type_a,
    input  br_pred_pkg::pd_type_t pd_type_b,
    output logic                  ex_valid_a,
    output logic                  ex_valid_b,
    output br_isa_pkg::addr_t     ex_pc_a,
    output br_isa_pkg::addr_t     ex_pc_b,
    output br_isa_pkg::word_t     ex_rdata_a1,
    output br_isa_pkg::word_t     ex_rdata_a2,
    output br_isa_pkg::word_t     ex_rdata_b1,
    output br_isa_pkg::word_t     ex_rdata_b2,
    output br_isa_pkg::word_t     ex_imm_a,
    output br_isa_pkg::word_t     ex_imm_b,
    output br_isa_pkg::br_type_e  ex_br_type_a,
    output br_isa_pkg::br_type_e  ex_br_type_b,
    output logic                  ex_br_pd_a,
    output logic                  ex_br_pd_b,
    output br_isa_pkg::addr_t     ex_pc_pd_a,
    output br_isa_pkg::addr_t     ex_pc_pd_b,
    output br_pred_pkg::pd_type_t ex_pd_type_a,
    output br_pred_pkg::pd_type_t ex_pd_type_b
);

    // valids, the only control state here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid_a <= 1'b0;
            ex_valid_b <= 1'b0;
        end else if (!stall) begin
            ex_valid_a <= issue_valid_a & ~flush;   // wrong path loads empty
            ex_valid_b <= issue_valid_b & ~flush;
        end
    end

    // payload follows the valids, qualified by them downstream
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_pc_a      <= pc_a;
            ex_pc_b      <= pc_b;
            ex_rdata_a1  <= rdata_a1;
            ex_rdata_a2  <= rdata_a2;
            ex_rdata_b1  <= rdata_b1;
            ex_rdata_b2  <= rdata_b2;
            ex_imm_a     <= imm_a;
            ex_imm_b     <= imm_b;
            ex_br_type_a <= br_type_a;
            ex_br_type_b <= br_type_b;
            ex_br_pd_a   <= br_pd_a;
            ex_br_pd_b   <= br_pd_b;
            ex_pc_pd_a   <= pc_pd_a;
            ex_pc_pd_b   <= pc_pd_b;
            ex_pd_type_a <= pd_type_a;
            ex_pd_type_b <= pd_type_b;
        end
    end

endmodule

//--- hdl/fu_br.sv
`include "br_consts.svh"
`timescale 1ns/1ps

module fu_br (
    input  logic                 valid_a,          // slot a holds an inst
    input  logic                 valid_b,          // slot b holds an inst
    input  br_isa_pkg::addr_t    pc_a,
    input  br_isa_pkg::addr_t    pc_b,
    input  br_isa_pkg::word_t    rdata_a1,
    input  br_isa_pkg::word_t    rdata_a2,
    input  br_isa_pkg::word_t    rdata_b1,
    input  br_isa_pkg::word_t    rdata_b2,
    input  br_isa_pkg::word_t    imm_a,
    input  br_isa_pkg::word_t    imm_b,
    input  br_isa_pkg::br_type_e br_type_a,
    input  br_isa_pkg::br_type_e br_type_b,
    input  logic                 br_pd_a,          // predicted taken, slot a
    input  logic                 br_pd_b,          // predicted taken, slot b
    input  br_isa_pkg::addr_t    pc_pd_a,          // predicted target, slot a
    input  br_isa_pkg::addr_t    pc_pd_b,          // predicted target, slot b
    input  br_pred_pkg::pd_type_t pd_type_a,
    input  br_pred_pkg::pd_type_t pd_type_b,
    output logic                 redirect_a,       // slot a mispredicted
    output logic                 redirect,         // any slot mispredicted
    output br_isa_pkg::addr_t    redirect_pc,      // fetch restart address
    output logic                 pred_upd_valid,
    output br_isa_pkg::addr_t    pred_upd_pc,
    output br_pred_pkg::pd_type_t pred_upd_type,
    output br_isa_pkg::addr_t    pred_upd_target,
    output logic                 pred_upd_jump
);

    import br_isa_pkg::*;
    import br_pred_pkg::*;

    logic  taken_a, taken_b;                       // real direction
    addr_t target_a, target_b;                     // real target
    logic  redirect_b;                             // slot b mispredicted
    addr_t fix_pc_a, fix_pc_b;                     // per-slot restart pc
    logic  upd_sel_b;                              // feedback from slot b

    branch_cond i_cond_a (
        .br_type(br_type_a), .pc(pc_a), .imm(imm_a),
        .rdata1(rdata_a1), .rdata2(rdata_a2),
        .taken(taken_a), .target(target_a)
    );

    branch_cond i_cond_b (
        .br_type(br_type_b), .pc(pc_b), .imm(imm_b),
        .rdata1(rdata_b1), .rdata2(rdata_b2),
        .taken(taken_b), .target(target_b)
    );

    // wrong direction or wrong target on a real branch
    assign redirect_a = valid_a && (br_type_a != BR_NONE)
                        && ((br_pd_a != taken_a) || (pc_pd_a != target_a));
    assign redirect_b = valid_b && (br_type_b != BR_NONE)
                        && ((br_pd_b != taken_b) || (pc_pd_b != target_b));

    assign fix_pc_a = taken_a ? target_a : pc_a + addr_t'(`INST_BYTES);  // else fall through
    assign fix_pc_b = taken_b ? target_b : pc_b + addr_t'(`INST_BYTES);

    assign redirect    = redirect_a | redirect_b;
    assign redirect_pc = redirect_a ? fix_pc_a : fix_pc_b;  // older slot first

    assign upd_sel_b       = (pd_type_a == PD_NONE);         // a not cf, train b
    assign pred_upd_valid  = upd_sel_b ? (valid_b && (pd_type_b != PD_NONE))
                                       : valid_a;
    assign pred_upd_pc     = upd_sel_b ? pc_b : pc_a;
    assign pred_upd_type   = upd_sel_b ? pd_type_b : pd_type_a;
    assign pred_upd_target = upd_sel_b ? target_b : target_a;
    assign pred_upd_jump   = upd_sel_b ? taken_b : taken_a;

endmodule

//--- hdl/branch_cond.sv
`timescale 1ns/1ps

module branch_cond (
    input  br_isa_pkg::br_type_e br_type,   // decoded branch kind
    input  br_isa_pkg::addr_t    pc,        // pc of the branch
    input  br_isa_pkg::word_t    imm,       // sign-extended offset
    input  br_isa_pkg::word_t    rdata1,    // first source operand
    input  br_isa_pkg::word_t    rdata2,    // second source operand
    output logic                 taken,     // branch really taken
    output br_isa_pkg::addr_t    target     // real jump target
);

    import br_isa_pkg::*;

    logic  eq;                                  // operands equal
    logic  lt_s;                                // signed less than
    logic  lt_u;                                // unsigned less than
    addr_t pc_rel;                              // pc relative target
    addr_t reg_rel;                             // register relative target

    assign eq      = (rdata1 == rdata2);
    assign lt_s    = ($signed(rdata1) < $signed(rdata2));
    assign lt_u    = (rdata1 < rdata2);
    assign pc_rel  = pc + imm;
    assign reg_rel = rdata1 + imm;              // jirl base is rj

    always_comb begin
        case (br_type)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = ~eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = ~lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = ~lt_u;
            BR_B,
            BR_BL,
            BR_JIRL: taken = 1'b1;              // always jump
            default: taken = 1'b0;              // none or unused code
        endcase
    end

    assign target = (br_type == BR_JIRL) ? reg_rel : pc_rel;

endmodule

//--- hdl/br_pred_pkg.sv
`include "br_consts.svh"

package br_pred_pkg;

    // predictor class of a slot
    // 0 none, others cond, call, ret or indirect
    typedef logic [1:0] pd_type_t;

    localparam pd_type_t PD_NONE = 2'b00;   // not a control-flow inst

    typedef logic [`PERF_CNT_W-1:0] perf_cnt_t;  // one perf counter
    typedef logic [1:0] perf_addr_t;             // perf register select

endpackage

//--- hdl/br_isa_pkg.sv
`include "br_consts.svh"

package br_isa_pkg;

    typedef logic [`WORD_W-1:0] word_t;     // operand or immediate
    typedef logic [`WORD_W-1:0] addr_t;     // instruction address

    // branch kinds as decoded into the issue slot
    // codes follow the decoder, so keep the order
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,                     // not a branch
        BR_BEQ  = 4'd1,                     // rj == rd
        BR_BNE  = 4'd2,                     // rj != rd
        BR_BLT  = 4'd3,                     // signed less
        BR_BGE  = 4'd4,                     // signed greater or equal
        BR_BLTU = 4'd5,                     // unsigned less
        BR_BGEU = 4'd6,                     // unsigned greater or equal
        BR_B    = 4'd7,                     // unconditional, pc relative
        BR_BL   = 4'd8,                     // call, pc relative
        BR_JIRL = 4'd9                      // register indirect jump
    } br_type_e;

endpackage

//--- hdl/br_consts.svh
`ifndef BR_CONSTS_SVH
`define BR_CONSTS_SVH

// datapath width of operands and pcs
`define WORD_W 32

// byte step to the sequential pc
`define INST_BYTES 4

// width of each perf counter
`define PERF_CNT_W 32

// perf register read addresses
`define PERF_ADDR_BR   2'd0
`define PERF_ADDR_MISS 2'd1
`define PERF_ADDR_LAST 2'd2

`endif
